// ==== hdl/dataPathPkg.sv ====
package dataPathPkg;

	// one bus word, also the width of every register
	typedef logic [31:0] word_t;
	typedef logic [3:0] regIndex_t;
	// one bit per general register, R0 in bit 0
	typedef logic [15:0] regMask_t;

	// rc overlaps the top of the immediate
	typedef struct packed {
		regIndex_t rc;
		logic [14:0] spare;
	} rcField_t;

	typedef union packed {
		rcField_t rField;
		logic [18:0] imm;
	} lowField_t;

	typedef struct packed {
		logic [4:0] opcode;
		regIndex_t ra;
		regIndex_t rb;
		lowField_t low;
	} instr_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr,
		aluShr, aluShra, aluShl, aluRor, aluRol,
		aluMul, aluNeg, aluNot, aluPass
	} aluOp_e;

	// teaching ISA opcode numbering
	localparam logic [4:0] opAdd = 5'd3;
	localparam logic [4:0] opSub = 5'd4;
	localparam logic [4:0] opAnd = 5'd5;
	localparam logic [4:0] opOr = 5'd6;
	localparam logic [4:0] opShr = 5'd7;
	localparam logic [4:0] opShra = 5'd8;
	localparam logic [4:0] opShl = 5'd9;
	localparam logic [4:0] opRor = 5'd10;
	localparam logic [4:0] opRol = 5'd11;
	localparam logic [4:0] opAddi = 5'd12;
	localparam logic [4:0] opAndi = 5'd13;
	localparam logic [4:0] opOri = 5'd14;
	localparam logic [4:0] opMul = 5'd15;
	localparam logic [4:0] opNeg = 5'd16;
	localparam logic [4:0] opNot = 5'd17;
	localparam logic [4:0] opBranch = 5'd19;

	// bus sources
	typedef struct packed {
		logic hiOut;
		logic loOut;
		logic zHighOut;
		logic zLowOut;
		logic pcOut;
		logic mdrOut;
		logic inPortOut;
		logic cOut;
	} busDrive_t;

	// bus destinations
	typedef struct packed {
		logic hiIn;
		logic loIn;
		logic zIn;
		logic pcIn;
		logic irIn;
		logic yIn;
		logic marIn;
		logic mdrIn;
		logic outPortIn;
		logic conIn;
	} regLoad_t;

	typedef struct packed {
		logic gra;
		logic grb;
		logic grc;
		logic rIn;
		logic rOut;
		logic baOut;
	} regSelect_t;

	typedef struct packed {
		logic read;
		logic write;
	} memCtrl_t;

endpackage

// ==== hdl/registerFile.sv ====
module registerFile (
	input logic clock,
	input logic rstN,
	input dataPathPkg::word_t busValue,
	input dataPathPkg::regMask_t regLoad,
	input dataPathPkg::regMask_t regDrive,
	input logic baOut,
	output dataPathPkg::word_t regOutValue
);

	// R0 to R15
	dataPathPkg::word_t regs [16];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (regLoad[i]) begin
					regs[i] <= busValue;
				end
			end
		end
	end

	// OR of the driven registers, at most one of them
	always_comb begin
		regOutValue = '0;
		for (int i = 1; i < 16; i++) begin
			if (regDrive[i]) begin
				regOutValue |= regs[i];
			end
		end
		// base addressing reads R0 as zero
		if (regDrive[0] && !baOut) begin
			regOutValue |= regs[0];
		end
	end

	// drive mask comes from the IR decode in selectEncode
	assert property (@(posedge clock) disable iff (!rstN)
		$onehot0(regDrive))
	else
		$error("register drive mask not one-hot: %h", regDrive);

endmodule

// ==== hdl/selectEncode.sv ====
module selectEncode (
	input dataPathPkg::instr_t ir,
	input dataPathPkg::regSelect_t select,
	output dataPathPkg::regMask_t regLoad,
	output dataPathPkg::regMask_t regDrive,
	output dataPathPkg::aluOp_e aluOp,
	output dataPathPkg::word_t cSignExt
);

	dataPathPkg::regIndex_t regNum;
	dataPathPkg::regMask_t oneHot;
	logic anyGroup;

	// pick the register field
	always_comb begin
		regNum = '0;
		if (select.gra) begin
			regNum = ir.ra;
		end else if (select.grb) begin
			regNum = ir.rb;
		end else if (select.grc) begin
			regNum = ir.low.rField.rc;
		end
	end

	assign anyGroup = select.gra | select.grb | select.grc;
	assign oneHot = dataPathPkg::regMask_t'(1) << regNum;

	// no field chosen means no register enable
	assign regLoad = (anyGroup && select.rIn) ? oneHot : '0;
	assign regDrive = (anyGroup && (select.rOut || select.baOut)) ? oneHot : '0;

	assign cSignExt = {{13{ir.low.imm[18]}}, ir.low.imm};

	always_comb begin
		case (ir.opcode)
			dataPathPkg::opAdd, dataPathPkg::opAddi: aluOp = dataPathPkg::aluAdd;
			dataPathPkg::opSub: aluOp = dataPathPkg::aluSub;
			dataPathPkg::opAnd, dataPathPkg::opAndi: aluOp = dataPathPkg::aluAnd;
			dataPathPkg::opOr, dataPathPkg::opOri: aluOp = dataPathPkg::aluOr;
			dataPathPkg::opShr: aluOp = dataPathPkg::aluShr;
			dataPathPkg::opShra: aluOp = dataPathPkg::aluShra;
			dataPathPkg::opShl: aluOp = dataPathPkg::aluShl;
			dataPathPkg::opRor: aluOp = dataPathPkg::aluRor;
			dataPathPkg::opRol: aluOp = dataPathPkg::aluRol;
			dataPathPkg::opMul: aluOp = dataPathPkg::aluMul;
			dataPathPkg::opNeg: aluOp = dataPathPkg::aluNeg;
			dataPathPkg::opNot: aluOp = dataPathPkg::aluNot;
			// branch target is PC plus C
			dataPathPkg::opBranch: aluOp = dataPathPkg::aluAdd;
			default: aluOp = dataPathPkg::aluPass;
		endcase
	end

	// only one register field at a time
	always_comb begin
		assert ($onehot0({select.gra, select.grb, select.grc}))
		else
			$error("more than one register field selected");
	end

endmodule

// ==== hdl/alu.sv ====
module alu (
	input dataPathPkg::word_t yValue,
	input dataPathPkg::word_t busValue,
	input dataPathPkg::aluOp_e op,
	output dataPathPkg::word_t resultHigh,
	output dataPathPkg::word_t resultLow
);

	logic [4:0] amount;
	// Y twice, so a rotate is one shift
	logic [63:0] doubled;
	logic [63:0] rotRight;
	logic [63:0] rotLeft;
	logic signed [63:0] ySigned;
	logic signed [63:0] busSigned;
	logic signed [63:0] product;

	// shift count from the bus
	assign amount = busValue[4:0];

	assign doubled = {yValue, yValue};
	assign rotRight = doubled >> amount;
	assign rotLeft = doubled << amount;

	assign ySigned = {{32{yValue[31]}}, yValue};
	assign busSigned = {{32{busValue[31]}}, busValue};
	assign product = ySigned * busSigned;

	always_comb begin
		resultLow = '0;
		case (op)
			dataPathPkg::aluAdd: begin
				resultLow = yValue + busValue;
			end
			dataPathPkg::aluSub: begin
				resultLow = yValue - busValue;
			end
			dataPathPkg::aluAnd: begin
				resultLow = yValue & busValue;
			end
			dataPathPkg::aluOr: begin
				resultLow = yValue | busValue;
			end
			dataPathPkg::aluShr: begin
				resultLow = yValue >> amount;
			end
			dataPathPkg::aluShra: begin
				resultLow = $signed(yValue) >>> amount;
			end
			dataPathPkg::aluShl: begin
				resultLow = yValue << amount;
			end
			dataPathPkg::aluRor: begin
				resultLow = rotRight[31:0];
			end
			dataPathPkg::aluRol: begin
				resultLow = rotLeft[63:32];
			end
			dataPathPkg::aluMul: begin
				resultLow = product[31:0];
			end
			dataPathPkg::aluNeg: begin
				resultLow = 32'd0 - busValue;
			end
			dataPathPkg::aluNot: begin
				resultLow = ~busValue;
			end
			default: begin
				resultLow = busValue;
			end
		endcase
	end

	// full product for mul, sign fill otherwise
	assign resultHigh = (op == dataPathPkg::aluMul) ? product[63:32] : {32{resultLow[31]}};

endmodule

// ==== hdl/memoryUnit.sv ====
module memoryUnit #(
	parameter int addrBits = 9
) (
	input logic clock,
	input logic rstN,
	input dataPathPkg::word_t busValue,
	input logic marIn,
	input logic mdrIn,
	input dataPathPkg::memCtrl_t mem,
	output dataPathPkg::word_t mdrValue
);

	logic [addrBits-1:0] mar;
	dataPathPkg::word_t ram [2**addrBits];
	dataPathPkg::word_t ramWord;
	dataPathPkg::word_t mdr;

	// word address from the bus
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
		end else if (marIn) begin
			mar <= busValue[addrBits-1:0];
		end
	end

	// read is combinational from MAR
	assign ramWord = ram[mar];

	always_ff @(posedge clock) begin
		if (mem.write) begin
			ram[mar] <= busValue;
		end
	end

	// MDR takes the RAM word on a read, else the bus
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mdr <= '0;
		end else if (mdrIn) begin
			mdr <= mem.read ? ramWord : busValue;
		end
	end

	assign mdrValue = mdr;

	assert property (@(posedge clock) disable iff (!rstN)
		!(mem.read && mem.write))
	else
		$error("RAM read and write in the same cycle");

endmodule

// ==== hdl/branchCondition.sv ====
module branchCondition (
	input logic clock,
	input logic rstN,
	input dataPathPkg::instr_t ir,
	input dataPathPkg::word_t busValue,
	input logic conIn,
	output logic branchTaken
);

	logic [1:0] condCode;
	logic isZero;
	logic isNegative;
	logic condMet;

	// low two bits of rb
	assign condCode = ir.rb[1:0];
	assign isZero = (busValue == '0);
	assign isNegative = busValue[31];

	always_comb begin
		case (condCode)
			2'd0: condMet = isZero;
			2'd1: condMet = !isZero;
			2'd2: condMet = !isNegative && !isZero;
			default: condMet = isNegative;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			branchTaken <= 1'b0;
		end else if (conIn) begin
			branchTaken <= condMet;
		end
	end

endmodule

// ==== hdl/dataPath.sv ====
module dataPath #(
	parameter int addrBits = 9
) (
	input logic clock,
	input logic rstN,
	input dataPathPkg::busDrive_t drive,
	input dataPathPkg::regLoad_t load,
	input dataPathPkg::regSelect_t select,
	input dataPathPkg::memCtrl_t mem,
	input logic incPc,
	input dataPathPkg::word_t inPortData,
	input logic inStrobe,
	output dataPathPkg::word_t busValue,
	output dataPathPkg::word_t outPortData,
	output dataPathPkg::instr_t irValue,
	output logic branchTaken,
	output dataPathPkg::word_t zHighValue
);

	dataPathPkg::word_t hi;
	dataPathPkg::word_t lo;
	dataPathPkg::word_t y;
	dataPathPkg::word_t zHigh;
	dataPathPkg::word_t zLow;
	dataPathPkg::word_t pc;
	dataPathPkg::word_t inPort;
	dataPathPkg::word_t outPort;
	dataPathPkg::instr_t ir;

	dataPathPkg::regMask_t regLoad;
	dataPathPkg::regMask_t regDrive;
	dataPathPkg::aluOp_e aluOp;
	dataPathPkg::word_t cSignExt;
	dataPathPkg::word_t regOutValue;
	dataPathPkg::word_t aluHigh;
	dataPathPkg::word_t aluLow;
	dataPathPkg::word_t mdrValue;
	dataPathPkg::word_t pcPlusOne;
	dataPathPkg::word_t zLowNext;

	selectEncode selectEncode_inst (
		.ir(ir),
		.select(select),
		.regLoad(regLoad),
		.regDrive(regDrive),
		.aluOp(aluOp),
		.cSignExt(cSignExt)
	);

	registerFile registerFile_inst (
		.clock(clock),
		.rstN(rstN),
		.busValue(busValue),
		.regLoad(regLoad),
		.regDrive(regDrive),
		.baOut(select.baOut),
		.regOutValue(regOutValue)
	);

	alu alu_inst (
		.yValue(y),
		.busValue(busValue),
		.op(aluOp),
		.resultHigh(aluHigh),
		.resultLow(aluLow)
	);

	memoryUnit #(
		.addrBits(addrBits)
	) memoryUnit_inst (
		.clock(clock),
		.rstN(rstN),
		.busValue(busValue),
		.marIn(load.marIn),
		.mdrIn(load.mdrIn),
		.mem(mem),
		.mdrValue(mdrValue)
	);

	branchCondition branchCondition_inst (
		.clock(clock),
		.rstN(rstN),
		.ir(ir),
		.busValue(busValue),
		.conIn(load.conIn),
		.branchTaken(branchTaken)
	);

	// the bus, zero when nothing drives it
	always_comb begin
		busValue = regOutValue;
		if (drive.hiOut) busValue |= hi;
		if (drive.loOut) busValue |= lo;
		if (drive.zHighOut) busValue |= zHigh;
		if (drive.zLowOut) busValue |= zLow;
		if (drive.pcOut) busValue |= pc;
		if (drive.mdrOut) busValue |= mdrValue;
		if (drive.inPortOut) busValue |= inPort;
		if (drive.cOut) busValue |= cSignExt;
	end

	// PC incrementer feeds Z low
	assign pcPlusOne = pc + 32'd1;
	assign zLowNext = incPc ? pcPlusOne : aluLow;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
			y <= '0;
			zHigh <= '0;
			zLow <= '0;
			pc <= '0;
			ir <= '0;
			inPort <= '0;
			outPort <= '0;
		end else begin
			if (load.hiIn) hi <= busValue;
			if (load.loIn) lo <= busValue;
			if (load.yIn) y <= busValue;
			if (load.zIn) begin
				zHigh <= aluHigh;
				zLow <= zLowNext;
			end
			if (load.pcIn) pc <= busValue;
			if (load.irIn) ir <= busValue;
			if (inStrobe) inPort <= inPortData;
			if (load.outPortIn) outPort <= busValue;
		end
	end

	assign outPortData = outPort;
	assign irValue = ir;
	assign zHighValue = zHigh;

	// one source per cycle, named strobes and decoded registers together
	assert property (@(posedge clock) disable iff (!rstN)
		$onehot0({drive, |regDrive}))
	else
		$error("bus driven by more than one source");

endmodule

// ==== bench/dataPathTb.sv ====
module dataPathTb;

	localparam int addrBits = 9;
	localparam int resetTimeout = 4;
	localparam int memWrites = 12;

	logic clock;
	logic rstN;
	dataPathPkg::busDrive_t drive;
	dataPathPkg::regLoad_t load;
	dataPathPkg::regSelect_t select;
	dataPathPkg::memCtrl_t mem;
	logic incPc;
	dataPathPkg::word_t inPortData;
	logic inStrobe;
	dataPathPkg::word_t busValue;
	dataPathPkg::word_t outPortData;
	dataPathPkg::instr_t irValue;
	logic branchTaken;
	dataPathPkg::word_t zHighValue;

	logic [31:0] lfsrState;
	// last word stored at each RAM address
	dataPathPkg::word_t memModel [2**addrBits];
	// opcode 0 stands for every opcode that passes the bus
	logic [4:0] aluOpcodes [16] = '{
		dataPathPkg::opAdd, dataPathPkg::opSub, dataPathPkg::opAnd, dataPathPkg::opOr,
		dataPathPkg::opShr, dataPathPkg::opShra, dataPathPkg::opShl, dataPathPkg::opRor,
		dataPathPkg::opRol, dataPathPkg::opAddi, dataPathPkg::opAndi, dataPathPkg::opOri,
		dataPathPkg::opMul, dataPathPkg::opNeg, dataPathPkg::opNot, 5'd0
	};

	dataPath #(
		.addrBits(addrBits)
	) dataPath_inst (
		.clock(clock),
		.rstN(rstN),
		.drive(drive),
		.load(load),
		.select(select),
		.mem(mem),
		.incPc(incPc),
		.inPortData(inPortData),
		.inStrobe(inStrobe),
		.busValue(busValue),
		.outPortData(outPortData),
		.irValue(irValue),
		.branchTaken(branchTaken),
		.zHighValue(zHighValue)
	);

	always #4 clock = ~clock;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic dataPathPkg::word_t randomBits(int count);
		dataPathPkg::word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic dataPathPkg::aluOp_e aluOpFor(logic [4:0] opcode);
		case (opcode)
			dataPathPkg::opAdd, dataPathPkg::opAddi: return dataPathPkg::aluAdd;
			dataPathPkg::opSub: return dataPathPkg::aluSub;
			dataPathPkg::opAnd, dataPathPkg::opAndi: return dataPathPkg::aluAnd;
			dataPathPkg::opOr, dataPathPkg::opOri: return dataPathPkg::aluOr;
			dataPathPkg::opShr: return dataPathPkg::aluShr;
			dataPathPkg::opShra: return dataPathPkg::aluShra;
			dataPathPkg::opShl: return dataPathPkg::aluShl;
			dataPathPkg::opRor: return dataPathPkg::aluRor;
			dataPathPkg::opRol: return dataPathPkg::aluRol;
			dataPathPkg::opMul: return dataPathPkg::aluMul;
			dataPathPkg::opNeg: return dataPathPkg::aluNeg;
			dataPathPkg::opNot: return dataPathPkg::aluNot;
			default: return dataPathPkg::aluPass;
		endcase
	endfunction

	// expected {Z high, Z low} with shifts done one bit at a time
	function automatic logic [63:0] expectedAlu(dataPathPkg::aluOp_e op,
			dataPathPkg::word_t y, dataPathPkg::word_t b);
		dataPathPkg::word_t low;
		int n;
		longint ys;
		longint bs;
		longint prod;
		n = int'(b[4:0]);
		low = y;
		case (op)
			dataPathPkg::aluAdd: low = y + b;
			dataPathPkg::aluSub: low = y + ~b + 32'd1;
			dataPathPkg::aluAnd: low = y & b;
			dataPathPkg::aluOr: low = y | b;
			dataPathPkg::aluShr: begin
				for (int i = 0; i < n; i++) low = {1'b0, low[31:1]};
			end
			dataPathPkg::aluShra: begin
				for (int i = 0; i < n; i++) low = {low[31], low[31:1]};
			end
			dataPathPkg::aluShl: begin
				for (int i = 0; i < n; i++) low = {low[30:0], 1'b0};
			end
			dataPathPkg::aluRor: begin
				for (int i = 0; i < n; i++) low = {low[0], low[31:1]};
			end
			dataPathPkg::aluRol: begin
				for (int i = 0; i < n; i++) low = {low[30:0], low[31]};
			end
			dataPathPkg::aluMul: begin
				ys = $signed(y);
				bs = $signed(b);
				prod = ys * bs;
				return prod;
			end
			dataPathPkg::aluNeg: low = ~b + 32'd1;
			dataPathPkg::aluNot: low = ~b;
			default: low = b;
		endcase
		return {{32{low[31]}}, low};
	endfunction

	function automatic dataPathPkg::word_t extendImm(logic [18:0] imm);
		if (imm[18]) begin
			return {13'h1fff, imm};
		end else begin
			return {13'h0000, imm};
		end
	endfunction

	function automatic logic expectedBranch(logic [1:0] code, dataPathPkg::word_t value);
		if (code == 2'd0) begin
			return value == 32'd0;
		end else if (code == 2'd1) begin
			return value != 32'd0;
		end else if (code == 2'd2) begin
			return !value[31] && value != 32'd0;
		end else begin
			return value[31];
		end
	endfunction

	task automatic stopRun();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWord(string name, dataPathPkg::word_t got,
			dataPathPkg::word_t expected);
		if (got !== expected) begin
			$display("FAIL time %0t: %s is %h, expected %h", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkBit(string name, logic got, logic expected);
		if (got !== expected) begin
			$display("FAIL time %0t: %s is %b, expected %b", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkInstr(string name, dataPathPkg::instr_t got,
			dataPathPkg::instr_t expected);
		if (got !== expected) begin
			$display("FAIL time %0t: %s is %h, expected %h", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic clearControls();
		drive = '0;
		load = '0;
		select = '0;
		mem = '0;
		incPc = 1'b0;
		inStrobe = 1'b0;
	endtask

	// commits the strobes of the open cycle and opens the next one
	task automatic nextCycle();
		@(posedge clock);
		#1;
		clearControls();
	endtask

	// leaves the word on the bus for the destination strobes the caller adds
	task automatic busFromPort(dataPathPkg::word_t value);
		nextCycle();
		inPortData = value;
		inStrobe = 1'b1;
		nextCycle();
		drive.inPortOut = 1'b1;
	endtask

	task automatic loadIr(dataPathPkg::instr_t instr);
		busFromPort(dataPathPkg::word_t'(instr));
		load.irIn = 1'b1;
		nextCycle();
		checkInstr("irValue", irValue, instr);
	endtask

	task automatic waitResetClear();
		int cycles;
		cycles = 0;
		while (outPortData !== '0 || irValue !== '0 || zHighValue !== '0
				|| branchTaken !== 1'b0) begin
			if (cycles == resetTimeout) begin
				$display("DUT registers were not cleared %0d cycles after reset", cycles);
				stopRun();
			end
			@(posedge clock);
			cycles++;
		end
	endtask

	task automatic testRegisterMoves();
		dataPathPkg::word_t written [16];
		dataPathPkg::instr_t instr;
		for (int r = 1; r < 16; r++) begin
			written[r] = randomBits(32);
			instr = dataPathPkg::instr_t'(randomBits(32));
			instr.low.rField.rc = dataPathPkg::regIndex_t'(r);
			loadIr(instr);
			busFromPort(written[r]);
			select.grc = 1'b1;
			select.rIn = 1'b1;
		end
		// read back after all writes so aliasing shows up
		for (int r = 1; r < 16; r++) begin
			instr = dataPathPkg::instr_t'(randomBits(32));
			instr.low.rField.rc = dataPathPkg::regIndex_t'(r);
			loadIr(instr);
			select.grc = 1'b1;
			select.rOut = 1'b1;
			load.outPortIn = 1'b1;
			#1;
			checkWord("busValue", busValue, written[r]);
			nextCycle();
			#1;
			checkWord("outPortData", outPortData, written[r]);
		end
	endtask

	task automatic testAluOps();
		dataPathPkg::instr_t instr;
		dataPathPkg::word_t yOperand;
		dataPathPkg::word_t busOperand;
		logic [63:0] expected;
		for (int k = 0; k < 16; k++) begin
			instr = dataPathPkg::instr_t'(randomBits(32));
			instr.opcode = aluOpcodes[k];
			loadIr(instr);
			for (int t = 0; t < 3; t++) begin
				yOperand = randomBits(32);
				busOperand = randomBits(32);
				expected = expectedAlu(aluOpFor(aluOpcodes[k]), yOperand, busOperand);
				busFromPort(yOperand);
				load.yIn = 1'b1;
				busFromPort(busOperand);
				load.zIn = 1'b1;
				nextCycle();
				drive.zLowOut = 1'b1;
				#1;
				checkWord("busValue", busValue, expected[31:0]);
				checkWord("zHighValue", zHighValue, expected[63:32]);
				nextCycle();
				drive.zHighOut = 1'b1;
				#1;
				checkWord("busValue", busValue, expected[63:32]);
			end
		end
	endtask

	task automatic testConstantAndR0();
		dataPathPkg::instr_t instr;
		dataPathPkg::word_t r0Value;
		instr = dataPathPkg::instr_t'(randomBits(32));
		instr.ra = '0;
		loadIr(instr);
		r0Value = randomBits(32) | 32'h1;
		busFromPort(r0Value);
		select.gra = 1'b1;
		select.rIn = 1'b1;
		nextCycle();
		select.gra = 1'b1;
		select.rOut = 1'b1;
		#1;
		checkWord("busValue", busValue, r0Value);
		// base addressing hides R0
		nextCycle();
		select.gra = 1'b1;
		select.baOut = 1'b1;
		#1;
		checkWord("busValue", busValue, 32'd0);
		for (int k = 0; k < 6; k++) begin
			instr = dataPathPkg::instr_t'(randomBits(32));
			instr.low.imm[18] = k[0];
			loadIr(instr);
			drive.cOut = 1'b1;
			#1;
			checkWord("busValue", busValue, extendImm(instr.low.imm));
		end
	endtask

	task automatic testMemory();
		logic [addrBits-1:0] addrs [memWrites];
		dataPathPkg::word_t raw;
		dataPathPkg::word_t data;
		for (int i = 0; i < memWrites; i++) begin
			raw = randomBits(addrBits);
			addrs[i] = raw[addrBits-1:0];
			data = randomBits(32);
			memModel[addrs[i]] = data;
			busFromPort(dataPathPkg::word_t'(addrs[i]));
			load.marIn = 1'b1;
			busFromPort(data);
			mem.write = 1'b1;
		end
		for (int i = 0; i < memWrites; i++) begin
			busFromPort(dataPathPkg::word_t'(addrs[i]));
			load.marIn = 1'b1;
			nextCycle();
			mem.read = 1'b1;
			load.mdrIn = 1'b1;
			nextCycle();
			drive.mdrOut = 1'b1;
			#1;
			checkWord("busValue", busValue, memModel[addrs[i]]);
		end
	endtask

	task automatic testBranch();
		dataPathPkg::instr_t instr;
		dataPathPkg::word_t value;
		logic [1:0] code;
		for (int c = 0; c < 4; c++) begin
			code = c[1:0];
			instr = dataPathPkg::instr_t'(randomBits(32));
			instr.rb[1:0] = code;
			loadIr(instr);
			// zero, positive, negative
			for (int kind = 0; kind < 3; kind++) begin
				if (kind == 0) begin
					value = 32'd0;
				end else if (kind == 1) begin
					value = (randomBits(32) & 32'h7fffffff) | 32'h1;
				end else begin
					value = randomBits(32) | 32'h80000000;
				end
				busFromPort(value);
				load.conIn = 1'b1;
				nextCycle();
				#1;
				checkBit("branchTaken", branchTaken, expectedBranch(code, value));
			end
		end
	endtask

	task automatic testPcIncrement();
		dataPathPkg::word_t pcStart;
		for (int k = 0; k < 4; k++) begin
			// last pass checks the wrap
			pcStart = (k == 3) ? 32'hffffffff : randomBits(32);
			busFromPort(pcStart);
			load.pcIn = 1'b1;
			nextCycle();
			drive.pcOut = 1'b1;
			incPc = 1'b1;
			load.zIn = 1'b1;
			#1;
			checkWord("busValue", busValue, pcStart);
			nextCycle();
			drive.zLowOut = 1'b1;
			#1;
			checkWord("busValue", busValue, pcStart + 32'd1);
		end
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		inPortData = '0;
		clearControls();
		lfsrState = 32'd50745;
		repeat (4) @(posedge clock);
		#1;
		rstN = 1'b1;
		waitResetClear();
		testRegisterMoves();
		testAluOps();
		testConstantAndR0();
		testMemory();
		testBranch();
		testPcIncrement();
		nextCycle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/dataPathPkg.sv
hdl/registerFile.sv
hdl/selectEncode.sv
hdl/alu.sv
hdl/memoryUnit.sv
hdl/branchCondition.sv
hdl/dataPath.sv
bench/dataPathTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dataPathTb -f list.f
	./obj_dir/VdataPathTb

clean:
	rm -rf obj_dir
